/* common/sf_pkg.sv */
// shared widths, register map and bus/datapath types for the video control block; compile first
package sf_pkg;

   // ==============================
   // bus and datapath widths
   // ==============================
   localparam int SF_ADDR_W = 8;
   localparam int SF_DATA_W = 16;
   localparam int SF_SCRL_W = 9;

   // 48 MHz / 12 gives the 4 MHz cpu enable
   localparam int SF_ENA_DIV = 12;

   // ==============================
   // register map
   // ==============================
   localparam logic [SF_ADDR_W-1:0] REG_SHF_CMD  = 8'h00;
   localparam logic [SF_ADDR_W-1:0] REG_SHF_LOAD = 8'h04;
   // read only
   localparam logic [SF_ADDR_W-1:0] REG_SHF_Q    = 8'h08;
   localparam logic [SF_ADDR_W-1:0] REG_SCROLL   = 8'h0C;
   localparam logic [SF_ADDR_W-1:0] REG_OBJ_POS  = 8'h10;
   localparam logic [SF_ADDR_W-1:0] REG_TARGET   = 8'h14;
   // read only
   localparam logic [SF_ADDR_W-1:0] REG_CMP_RES  = 8'h18;

   // apb request from the master
   typedef struct packed {
      logic                 psel;
      logic                 penable;
      logic                 pwrite;
      logic [SF_ADDR_W-1:0] paddr;
      logic [SF_DATA_W-1:0] pwdata;
   } apb_req_t;

   // apb response back to the master
   typedef struct packed {
      logic [SF_DATA_W-1:0] prdata;
      logic                 pready;
      logic                 pslverr;
   } apb_rsp_t;

   // same S1:S0 encoding as the 74194 mode pins
   typedef enum logic [1:0] {
      SHF_HOLD  = 2'b00,
      SHF_LEFT  = 2'b01,
      SHF_RIGHT = 2'b10,
      SHF_LOAD  = 2'b11
   } shift_mode_e;

   // register layout: left serial in bit 3, right serial in bit 2, mode in 1:0
   typedef struct packed {
      logic        ser_l;
      logic        ser_r;
      shift_mode_e mode;
   } shift_cmd_t;

   // one-cycle enables derived from clk
   typedef struct packed {
      logic pix12;
      logic pix6;
      logic cpu4;
      logic snd2;
   } clk_en_t;

   // adder sum plus 7485-style compare flags
   typedef struct packed {
      logic [SF_SCRL_W-1:0] sum;
      logic                 carry;
      logic                 a_lt_b;
      logic                 a_eq_b;
      logic                 a_gt_b;
   } cmp_res_t;

endpackage

/* hdl/sf_clk_en_gen.sv */
// enable generator: divides the 48 MHz clk into one-cycle pixel, cpu and sound enables
module sf_clk_en_gen
   import sf_pkg::*;
(
   input  logic    clk,
   input  logic    CR,
   output clk_en_t clk_en_o
);

   localparam int DIV_W = $clog2(SF_ENA_DIV);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SF_ENA_DIV - 1);

   logic [1:0]       cnt4;
   logic [DIV_W-1:0] cnt12;
   // half-rate phases for 6 MHz and 2 MHz
   logic             ph6;
   logic             ph2;
   logic             wrap4;
   logic             wrap12;

   assign wrap4  = (cnt4 == 2'd3);
   assign wrap12 = (cnt12 == DIV_LAST);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         cnt4     <= '0;
         cnt12    <= '0;
         ph6      <= 1'b0;
         ph2      <= 1'b0;
         clk_en_o <= '0;
      end
      else
      begin
         cnt4  <= cnt4 + 2'd1;
         cnt12 <= wrap12 ? '0 : cnt12 + 1'b1;
         if (wrap4)
            ph6 <= ~ph6;
         if (wrap12)
            ph2 <= ~ph2;
         // registered so each pulse is exactly one clk wide
         clk_en_o.pix12 <= wrap4;
         clk_en_o.pix6  <= wrap4 & ph6;
         clk_en_o.cpu4  <= wrap12;
         clk_en_o.snd2  <= wrap12 & ph2;
      end
   end

endmodule

/* hdl/sf_apb_regs.sv */
// apb register block: decodes addresses, holds the control registers, reads back datapath results
module sf_apb_regs
   import sf_pkg::*;
#(
   parameter int PLANE0_W = 8,
   parameter int PLANE1_W = 4
)
(
   input  logic                 clk,
   input  logic                 CR,
   input  apb_req_t             apb_req_i,
   output apb_rsp_t             apb_rsp_o,
   output shift_cmd_t           shf_cmd_o,
   output logic [PLANE0_W-1:0]  load0_o,
   output logic [PLANE1_W-1:0]  load1_o,
   input  logic [PLANE0_W-1:0]  q0_i,
   input  logic [PLANE1_W-1:0]  q1_i,
   output logic [SF_SCRL_W-1:0] scroll_o,
   output logic [SF_SCRL_W-1:0] obj_pos_o,
   output logic [SF_SCRL_W-1:0] target_o,
   output logic                 carry_o,
   input  cmp_res_t             cmp_res_i
);

   // plane 1 sits in the upper byte of load and q words
   localparam int PLANE1_LSB = 8;

   logic sel_cmd;
   logic sel_load;
   logic sel_q;
   logic sel_scroll;
   logic sel_pos;
   logic sel_tgt;
   logic sel_res;
   logic miss;
   logic read_only;
   logic access;
   logic err;
   logic wr_en;
   logic [SF_DATA_W-1:0] rd_mux;

   // ==============================
   // address decode (74138 role)
   // ==============================
   assign sel_cmd    = (apb_req_i.paddr == REG_SHF_CMD);
   assign sel_load   = (apb_req_i.paddr == REG_SHF_LOAD);
   assign sel_q      = (apb_req_i.paddr == REG_SHF_Q);
   assign sel_scroll = (apb_req_i.paddr == REG_SCROLL);
   assign sel_pos    = (apb_req_i.paddr == REG_OBJ_POS);
   assign sel_tgt    = (apb_req_i.paddr == REG_TARGET);
   assign sel_res    = (apb_req_i.paddr == REG_CMP_RES);

   assign miss      = ~(sel_cmd | sel_load | sel_q | sel_scroll | sel_pos | sel_tgt | sel_res);
   assign read_only = sel_q | sel_res;

   assign access = apb_req_i.psel & apb_req_i.penable;
   assign err    = miss | (apb_req_i.pwrite & read_only);
   // write lands on the edge that closes the access cycle
   assign wr_en  = access & apb_req_i.pwrite & ~err;

   // ==============================
   // control registers
   // ==============================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         shf_cmd_o <= '0;
         load0_o   <= '0;
         load1_o   <= '0;
         scroll_o  <= '0;
         carry_o   <= 1'b0;
         obj_pos_o <= '0;
         target_o  <= '0;
      end
      else if (wr_en)
      begin
         if (sel_cmd)
            shf_cmd_o <= shift_cmd_t'(apb_req_i.pwdata[3:0]);
         if (sel_load)
         begin
            load0_o <= apb_req_i.pwdata[PLANE0_W-1:0];
            load1_o <= apb_req_i.pwdata[PLANE1_LSB +: PLANE1_W];
         end
         if (sel_scroll)
         begin
            scroll_o <= apb_req_i.pwdata[SF_SCRL_W-1:0];
            // bit 9 is the adder carry-in
            carry_o  <= apb_req_i.pwdata[SF_SCRL_W];
         end
         if (sel_pos)
            obj_pos_o <= apb_req_i.pwdata[SF_SCRL_W-1:0];
         if (sel_tgt)
            target_o <= apb_req_i.pwdata[SF_SCRL_W-1:0];
      end
   end

   // read mux, combinational so compare results show in the same access cycle
   always_comb
   begin
      rd_mux = '0;
      if (sel_cmd)
         rd_mux[3:0] = shf_cmd_o;
      if (sel_load)
      begin
         rd_mux[PLANE0_W-1:0]            = load0_o;
         rd_mux[PLANE1_LSB +: PLANE1_W] = load1_o;
      end
      if (sel_q)
      begin
         rd_mux[PLANE0_W-1:0]            = q0_i;
         rd_mux[PLANE1_LSB +: PLANE1_W] = q1_i;
      end
      if (sel_scroll)
         rd_mux[SF_SCRL_W:0] = {carry_o, scroll_o};
      if (sel_pos)
         rd_mux[SF_SCRL_W-1:0] = obj_pos_o;
      if (sel_tgt)
         rd_mux[SF_SCRL_W-1:0] = target_o;
      if (sel_res)
         rd_mux[SF_SCRL_W+3:0] = {cmp_res_i.a_lt_b, cmp_res_i.a_eq_b, cmp_res_i.a_gt_b,
                                  cmp_res_i.carry, cmp_res_i.sum};
   end

   // no wait states
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = access & err;
   assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? rd_mux : '0;

endmodule

/* hdl/sf_plane_shifter.sv */
// bitplane shift register in the manner of a 74194, stepping only on the 6 MHz pixel enable
module sf_plane_shifter
   import sf_pkg::*;
#(
   parameter int PLANE_W = 8
)
(
   input  logic               clk,
   input  logic               CR,
   input  clk_en_t            clk_en_i,
   input  shift_cmd_t         cmd_i,
   input  logic [PLANE_W-1:0] load_i,
   output logic [PLANE_W-1:0] q_o
);

   logic [PLANE_W-1:0] q_next;

   // ==============================
   // mode select
   // ==============================
   always_comb
   begin
      case (cmd_i.mode)
         SHF_LOAD:
            q_next = load_i;
         // right serial input enters at bit 0
         SHF_LEFT:
            q_next = {q_o[PLANE_W-2:0], cmd_i.ser_r};
         // left serial input enters at the top bit
         SHF_RIGHT:
            q_next = {cmd_i.ser_l, q_o[PLANE_W-1:1]};
         default:
            q_next = q_o;
      endcase
   end

   // register only moves on pix6, otherwise holds
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         q_o <= '0;
      end
      else if (clk_en_i.pix6)
      begin
         q_o <= q_next;
      end
   end

endmodule

/* hdl/sf_scroll_cmp.sv */
// scroll adder chain and cascaded magnitude compare of the sum against a target, purely combinational
module sf_scroll_cmp
   import sf_pkg::*;
(
   input  logic [SF_SCRL_W-1:0] scroll_i,
   input  logic [SF_SCRL_W-1:0] obj_pos_i,
   input  logic [SF_SCRL_W-1:0] target_i,
   input  logic                 carry_i,
   output cmp_res_t             res_o
);

   // number of 4-bit slices covering the value width
   localparam int NIB = (SF_SCRL_W + 3) / 4;
   localparam int EXT_W = NIB * 4;

   logic [EXT_W-1:0] pos_ext;
   logic [EXT_W-1:0] scr_ext;
   logic [EXT_W-1:0] sum_ext;
   logic [EXT_W-1:0] cmp_a;
   logic [EXT_W-1:0] cmp_b;
   logic             c_chain;
   logic [2:0]       cascade;

   assign pos_ext = EXT_W'(obj_pos_i);
   assign scr_ext = EXT_W'(scroll_i);

   // ==============================
   // 74283 style adder chain
   // ==============================
   always_comb
   begin
      c_chain = carry_i;
      sum_ext = '0;
      for (int i = 0; i < NIB; i++)
      begin
         {c_chain, sum_ext[i*4 +: 4]} = {1'b0, pos_ext[i*4 +: 4]} + {1'b0, scr_ext[i*4 +: 4]}
                                        + {4'b0, c_chain};
      end
   end

   // carry out of the 9-bit sum lands in the first pad bit
   assign cmp_a = EXT_W'(sum_ext[SF_SCRL_W-1:0]);
   assign cmp_b = EXT_W'(target_i);

   // 7485 cascade, low slice first; cascade = {lt, eq, gt}
   always_comb
   begin
      cascade = 3'b010;
      for (int i = 0; i < NIB; i++)
      begin
         if (cmp_a[i*4 +: 4] > cmp_b[i*4 +: 4])
            cascade = 3'b001;
         else if (cmp_a[i*4 +: 4] < cmp_b[i*4 +: 4])
            cascade = 3'b100;
      end
   end

   assign res_o.sum    = sum_ext[SF_SCRL_W-1:0];
   assign res_o.carry  = sum_ext[SF_SCRL_W];
   assign res_o.a_lt_b = cascade[2];
   assign res_o.a_eq_b = cascade[1];
   assign res_o.a_gt_b = cascade[0];

endmodule

/* hdl/sf_video_ctl_top.sv */
// top level of the video control peripheral: apb in, enables, serial pixel and hit flag out
module sf_video_ctl_top
   import sf_pkg::*;
#(
   parameter int PLANE0_W = 8,
   parameter int PLANE1_W = 4
)
(
   input  logic     clk,
   input  logic     CR,
   input  apb_req_t apb_req_i,
   output apb_rsp_t apb_rsp_o,
   output clk_en_t  clk_en_o,
   output logic     ser_o,
   output logic     obj_hit_o
);

   clk_en_t              clk_en;
   shift_cmd_t           shf_cmd;
   logic [PLANE0_W-1:0]  load0;
   logic [PLANE1_W-1:0]  load1;
   logic [PLANE0_W-1:0]  q0;
   logic [PLANE1_W-1:0]  q1;
   logic [SF_SCRL_W-1:0] scroll;
   logic [SF_SCRL_W-1:0] obj_pos;
   logic [SF_SCRL_W-1:0] target;
   logic                 carry;
   cmp_res_t             cmp_res;

   sf_clk_en_gen u_clk_en (
      .clk      (clk),
      .CR       (CR),
      .clk_en_o (clk_en)
   );

   sf_apb_regs #(
      .PLANE0_W (PLANE0_W),
      .PLANE1_W (PLANE1_W)
   ) u_regs (
      .clk       (clk),
      .CR        (CR),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .shf_cmd_o (shf_cmd),
      .load0_o   (load0),
      .load1_o   (load1),
      .q0_i      (q0),
      .q1_i      (q1),
      .scroll_o  (scroll),
      .obj_pos_o (obj_pos),
      .target_o  (target),
      .carry_o   (carry),
      .cmp_res_i (cmp_res)
   );

   // ==============================
   // bitplanes, 8 and 4 wide
   // ==============================
   sf_plane_shifter #(.PLANE_W (PLANE0_W)) u_plane0 (
      .clk      (clk),
      .CR       (CR),
      .clk_en_i (clk_en),
      .cmd_i    (shf_cmd),
      .load_i   (load0),
      .q_o      (q0)
   );

   sf_plane_shifter #(.PLANE_W (PLANE1_W)) u_plane1 (
      .clk      (clk),
      .CR       (CR),
      .clk_en_i (clk_en),
      .cmd_i    (shf_cmd),
      .load_i   (load1),
      .q_o      (q1)
   );

   sf_scroll_cmp u_scroll (
      .scroll_i  (scroll),
      .obj_pos_i (obj_pos),
      .target_i  (target),
      .carry_i   (carry),
      .res_o     (cmp_res)
   );

   // hit flag registered once off the equal output
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         obj_hit_o <= 1'b0;
      else
         obj_hit_o <= cmp_res.a_eq_b;
   end

   assign clk_en_o = clk_en;
   assign ser_o    = q0[PLANE0_W-1];

endmodule

/* dv/sf_tb_asserts.sv */
// assertion checker bound into the video control top; watches enable spacing, apb response, reset
module sf_tb_asserts
   import sf_pkg::*;
(
   input logic     clk,
   input logic     CR,
   input clk_en_t  clk_en_i,
   input apb_req_t apb_req_i,
   input apb_rsp_t apb_rsp_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // cycles since the last pix6 pulse, saturating
   logic [3:0] pix6_gap;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         pix6_gap <= 4'hF;
      else if (clk_en_i.pix6)
         pix6_gap <= 4'h0;
      else if (pix6_gap != 4'hF)
         pix6_gap <= pix6_gap + 4'h1;
   end

   a_pix6_spacing: assert property (@(posedge clk) disable iff (!CR)
      clk_en_i.pix6 |-> pix6_gap >= 4'd7)
      else $error("pix6 pulse within 8 cycles of the previous one");

   a_pready: assert property (@(posedge clk) disable iff (!CR)
      apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
      else $error("pready low during an apb access cycle");

   a_reset_enables: assert property (@(posedge clk)
      !CR |-> clk_en_i == '0)
      else $error("clock enables active while reset is held");

endmodule

bind sf_video_ctl_top sf_tb_asserts u_asserts (
   .clk       (clk),
   .CR        (CR),
   .clk_en_i  (clk_en_o),
   .apb_req_i (apb_req_i),
   .apb_rsp_i (apb_rsp_o)
);

/* dv/sf_tb.sv */
// testbench for the video control top; replays dv/sf_stimulus.txt over apb and checks every result
module sf_tb
   import sf_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // four 96-cycle enable counts and two 8-pulse waits make up most of the run
   localparam int    MAX_CYCLES = 3000;
   localparam string STIM_FILE  = "dv/sf_stimulus.txt";

   logic     clk;
   logic     CR;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   clk_en_t  clk_en;
   logic     ser;
   logic     obj_hit;
   int       cycles;

   sf_video_ctl_top #(
      .PLANE0_W (8),
      .PLANE1_W (4)
   ) dut_i (
      .clk       (clk),
      .CR        (CR),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .clk_en_o  (clk_en),
      .ser_o     (ser),
      .obj_hit_o (obj_hit)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // run limit
   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("stimulus did not finish within %0d clock cycles", MAX_CYCLES);
      $display("** FAIL **");
      $fatal(1, "simulation timed out");
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("** FAIL **");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // ==============================
   // apb transfers, setup then access
   // ==============================
   task automatic apb_write(input logic [SF_ADDR_W-1:0] addr,
                            input logic [SF_DATA_W-1:0] data, input logic exp_err);
      apb_req_t req;
      req        = '0;
      req.psel   = 1'b1;
      req.pwrite = 1'b1;
      req.paddr  = addr;
      req.pwdata = data;
      @(posedge clk);
      apb_req <= req;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      check_value("pready", 32'(apb_rsp.pready), 32'd1);
      check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic apb_read(input logic [SF_ADDR_W-1:0] addr,
                           input logic [SF_DATA_W-1:0] exp_data, input logic exp_err);
      apb_req_t req;
      req       = '0;
      req.psel  = 1'b1;
      req.paddr = addr;
      @(posedge clk);
      apb_req <= req;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      check_value("pready", 32'(apb_rsp.pready), 32'd1);
      check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
      check_value("prdata", 32'(apb_rsp.prdata), 32'(exp_data));
      @(posedge clk);
      apb_req <= '0;
   endtask

   // returns on the edge where the shifters act on the last pulse
   task automatic wait_pix6(input int n);
      repeat (n)
      begin
         @(negedge clk);
         while (!clk_en.pix6)
            @(negedge clk);
      end
      @(posedge clk);
   endtask

   // idx is the bit of clk_en_t: 3 pix12, 2 pix6, 1 cpu4, 0 snd2
   task automatic count_enable(input logic [1:0] idx, input int n, input logic [31:0] expected);
      logic [31:0] hits;
      string       name;
      hits = '0;
      case (idx)
         2'd3:    name = "clk_en_o.pix12 pulses";
         2'd2:    name = "clk_en_o.pix6 pulses";
         2'd1:    name = "clk_en_o.cpu4 pulses";
         default: name = "clk_en_o.snd2 pulses";
      endcase
      repeat (n)
      begin
         @(negedge clk);
         hits = hits + 32'(clk_en[idx]);
      end
      check_value(name, hits, expected);
   endtask

   // ==============================
   // stimulus replay
   // ==============================
   initial
   begin
      int          fd;
      int          fields;
      int          line_no;
      string       line;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp_val;
      logic [31:0] exp_err;

      apb_req = '0;
      CR      = 1'b0;
      line_no = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file %s", STIM_FILE);
         $display("** FAIL **");
         $fatal(1, "missing stimulus file");
      end
      repeat (2)
         @(posedge clk);
      CR <= 1'b1;

      while ($fgets(line, fd) != 0)
      begin
         line_no++;
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, exp_val, exp_err);
         if (fields != 5)
         begin
            $display("stimulus line %0d does not hold five fields", line_no);
            $display("** FAIL **");
            $fatal(1, "malformed stimulus line");
         end
         case (op)
            "W":
               apb_write(addr[SF_ADDR_W-1:0], data[SF_DATA_W-1:0], exp_err[0]);
            "R":
               apb_read(addr[SF_ADDR_W-1:0], exp_val[SF_DATA_W-1:0], exp_err[0]);
            "P":
               wait_pix6(int'(data));
            "E":
               count_enable(addr[1:0], int'(data), exp_val);
            "S":
            begin
               @(negedge clk);
               check_value("ser_o", 32'(ser), exp_val);
            end
            "H":
            begin
               repeat (int'(data))
                  @(posedge clk);
               @(negedge clk);
               check_value("obj_hit_o", 32'(obj_hit), exp_val);
            end
            default:
            begin
               $display("stimulus line %0d has an unknown operation", line_no);
               $display("** FAIL **");
               $fatal(1, "unknown stimulus operation");
            end
         endcase
      end
      $fclose(fd);
      $display("** PASS **");
      $finish;
   end

endmodule

/* dv/sf_stimulus.txt */
# op addr data expected err, all hex; W write, R read, P wait data pix6 pulses,
# E count enable bit addr over data cycles, S check ser_o, H wait data cycles then check obj_hit_o
R 00 0000 0000 0
R 04 0000 0000 0
R 08 0000 0000 0
R 0C 0000 0000 0
E 03 0060 0018 0
E 02 0060 000C 0
E 01 0060 0008 0
E 00 0060 0004 0
W 04 F3A5 0000 0
R 04 0000 03A5 0
W 00 0003 0000 0
P 00 0001 0000 0
W 00 0000 0000 0
R 08 0000 03A5 0
S 00 0000 0001 0
W 00 0005 0000 0
P 00 0008 0000 0
R 08 0000 0FFF 0
S 00 0000 0001 0
W 00 0002 0000 0
P 00 0008 0000 0
R 08 0000 0000 0
S 00 0000 0000 0
R 1C 0000 0000 1
W 08 FFFF 0000 1
R 08 0000 0000 0
W 20 FFFF 0000 1
R 00 0000 0002 0
W 10 0064 0000 0
W 0C 0032 0000 0
W 14 0096 0000 0
R 18 0000 0896 0
H 00 0002 0001 0
W 0C 0232 0000 0
R 18 0000 0497 0
H 00 0002 0000 0
W 10 01F0 0000 0
W 0C 0020 0000 0
R 18 0000 1210 0
W 14 0010 0000 0
R 18 0000 0A10 0
H 00 0002 0001 0

/* src.f */
common/sf_pkg.sv
hdl/sf_clk_en_gen.sv
hdl/sf_apb_regs.sv
hdl/sf_plane_shifter.sv
hdl/sf_scroll_cmp.sv
hdl/sf_video_ctl_top.sv
dv/sf_tb_asserts.sv
dv/sf_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module sf_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vsf_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qxF "** PASS **"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
